// ==== icache.sv ====
module icache #(
    parameter int index_w = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  ifetch_pkg::fetch_req_t fetch_req,
    output ifetch_pkg::fetch_rsp_t fetch_rsp,
    output ifetch_pkg::mem_req_t   mem_req,
    input  ifetch_pkg::mem_rsp_t   mem_rsp
);
    localparam int lines = 1 << index_w;
    localparam int tag_w = ifetch_pkg::addr_w - 2 - index_w;

    typedef enum logic [1:0] {
        s_idle,
        s_compare,
        s_allocate
    } state_t;

    state_t state;

    logic [ifetch_pkg::addr_w-1:0] req_addr;  // Held for the whole transaction.
    logic [ifetch_pkg::addr_w-1:0] idx_full;
    logic [ifetch_pkg::addr_w-1:0] tag_full;
    logic [index_w-1:0]            idx;
    logic [tag_w-1:0]              tag;
    logic                          hit;
    logic                          accept;

    // Line store. Valid bits are cleared by reset.
    logic [lines-1:0]              line_valid;
    logic [tag_w-1:0]              tag_mem [lines];
    logic [ifetch_pkg::word_w-1:0] data_mem [lines];

    logic                          rsp_valid;
    logic [ifetch_pkg::word_w-1:0] rsp_data;
    logic                          miss_valid;

    assign idx_full = ifetch_pkg::index_of(req_addr, index_w);
    assign tag_full = ifetch_pkg::tag_of(req_addr, index_w);
    assign idx      = idx_full[index_w-1:0];
    assign tag      = tag_full[tag_w-1:0];

    assign hit = line_valid[idx] && (tag_mem[idx] == tag);

    // No new request while the previous response is still on the wire.
    assign accept = (state == s_idle) && fetch_req.valid && !rsp_valid;

    assign fetch_rsp = '{valid: rsp_valid, addr: req_addr, data: rsp_data};
    assign mem_req   = '{valid: miss_valid, addr: req_addr};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= s_idle;
            rsp_valid  <= 1'b0;
            miss_valid <= 1'b0;
            line_valid <= '0;
        end
        else
        begin
            rsp_valid <= 1'b0;
            case (state)
                s_idle:
                begin
                    if (accept)
                        state <= s_compare;
                end
                s_compare:
                begin
                    if (hit)
                    begin
                        rsp_valid <= 1'b1;
                        state     <= s_idle;
                    end
                    else
                    begin
                        miss_valid <= 1'b1;  // Fetch the word from memory.
                        state      <= s_allocate;
                    end
                end
                s_allocate:
                begin
                    if (mem_rsp.ready)
                    begin
                        miss_valid      <= 1'b0;
                        line_valid[idx] <= 1'b1;
                        state           <= s_compare;  // Compare again, now a hit.
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Payload and line fill.
    always_ff @(posedge clk)
    begin
        if (accept)
            req_addr <= fetch_req.addr;
        if (state == s_compare && hit)
            rsp_data <= data_mem[idx];
        if (state == s_allocate && mem_rsp.ready)
        begin
            tag_mem[idx]  <= tag;
            data_mem[idx] <= mem_rsp.data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_miss_steady: assert property (@(posedge clk) disable iff (rst)
        mem_req.valid && !mem_rsp.ready |=> mem_req.valid && $stable(mem_req.addr));

    // Request held by the PC unit until answered.
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        fetch_req.valid && !fetch_rsp.valid |=> fetch_req.valid && $stable(fetch_req.addr));

    // Response carries the word of a valid, matching line.
    a_rsp_on_hit: assert property (@(posedge clk) disable iff (rst)
        fetch_rsp.valid |-> line_valid[idx] && (tag_mem[idx] == tag)
                            && (fetch_rsp.data == data_mem[idx]));

endmodule

// ==== ifetch.f ====
ifetch_pkg.sv
ifetch_pc.sv
icache.sv
imem.sv
ifetch_top.sv
ifetch_tb.sv

// ==== ifetch_pc.sv ====
module ifetch_pc #(
    parameter logic [ifetch_pkg::addr_w-1:0] reset_pc = '0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  ifetch_pkg::redirect_t  redirect,
    output ifetch_pkg::fetch_req_t fetch_req,
    input  ifetch_pkg::fetch_rsp_t fetch_rsp,
    output ifetch_pkg::fetch_rsp_t instr
);
    localparam logic [ifetch_pkg::addr_w-1:0] word_step = 4;

    logic [ifetch_pkg::addr_w-1:0] pc;
    logic                          pending;
    logic                          redir_held;    // Redirect waiting for the response.
    logic [ifetch_pkg::addr_w-1:0] redir_target;
    logic                          stale;
    logic                          out_valid;
    logic [ifetch_pkg::addr_w-1:0] out_addr;
    logic [ifetch_pkg::word_w-1:0] out_data;

    // The response in flight belongs to a redirected request.
    assign stale = (redirect.valid && pending) || redir_held;

    assign fetch_req = '{valid: pending, addr: pc};
    assign instr     = '{valid: out_valid, addr: out_addr, data: out_data};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc         <= reset_pc;
            pending    <= 1'b0;
            redir_held <= 1'b0;
            out_valid  <= 1'b0;
        end
        else
        begin
            pending   <= 1'b1;
            out_valid <= fetch_rsp.valid && !stale;
            if (fetch_rsp.valid)
            begin
                redir_held <= 1'b0;
                if (redirect.valid)
                    pc <= redirect.target;
                else if (redir_held)
                    pc <= redir_target;
                else
                    pc <= pc + word_step;
            end
            else if (redirect.valid)
            begin
                if (pending)
                    redir_held <= 1'b1;
                else
                    pc <= redirect.target;  // Nothing in flight yet.
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (redirect.valid)
            redir_target <= redirect.target;  // Latest target wins.
        out_addr <= fetch_rsp.addr;
        out_data <= fetch_rsp.data;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_req_aligned: assert property (@(posedge clk) disable iff (rst)
        fetch_req.valid |-> fetch_req.addr[1:0] == 2'b00);

endmodule

// ==== ifetch_pkg.sv ====
package ifetch_pkg;

    localparam int addr_w = 16;  // Byte address.
    localparam int word_w = 32;  // Instruction word.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bundles between PC unit, cache and memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
        logic [word_w-1:0] data;
    } fetch_rsp_t;

    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic              ready;
        logic [word_w-1:0] data;
    } mem_rsp_t;

    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] target;
    } redirect_t;

    // Line index of a byte address, one word per line.
    function automatic logic [addr_w-1:0] index_of(input logic [addr_w-1:0] addr,
                                                   input int index_w);
        logic [addr_w-1:0] mask;
        mask = (addr_w'(1) << index_w) - addr_w'(1);
        return (addr >> 2) & mask;
    endfunction

    function automatic logic [addr_w-1:0] tag_of(input logic [addr_w-1:0] addr,
                                                 input int index_w);
        return addr >> (2 + index_w);
    endfunction

endpackage

// ==== ifetch_tb.sv ====
module ifetch_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int mem_latency = 3;
    localparam int hit_gap     = 3;
    localparam int miss_gap    = hit_gap + mem_latency + 2;
    localparam int cycle_limit = 4000;  // About four times the whole run.

    logic                   clk;
    logic                   rst;
    ifetch_pkg::redirect_t  redirect;
    ifetch_pkg::fetch_rsp_t instr;

    logic [ifetch_pkg::word_w-1:0] ref_rom [32];
    logic [ifetch_pkg::addr_w-1:0] exp_pc;
    int                            cycle;       // Falling edges since reset.
    int                            last_out;    // Cycle of previous output, -1 for none.
    int                            expect_gap;  // 0 when the gap is free.
    int                            n_out;
    int                            cycles_run;

    ifetch_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .redirect (redirect),
        .instr    (instr)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial
    begin
        cycles_run = 0;
        while (cycles_run < cycle_limit)
        begin
            @(posedge clk);
            cycles_run++;
        end
        abort_run("Timeout: the fetch unit stopped delivering instructions.");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        abort_run($sformatf("FAIL at %0t ns: %s = 0x%h, expected 0x%h",
                            $time, name, got, expected));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_output();
        int gap;
        if (instr.valid)
        begin
            gap = cycle - last_out;
            assert (instr.addr == exp_pc)
                else report_mismatch("instr.addr", 32'(instr.addr), 32'(exp_pc));
            assert (instr.data == ref_rom[exp_pc[6:2]])  // ROM wraps at 32 words.
                else report_mismatch("instr.data", instr.data, ref_rom[exp_pc[6:2]]);
            if (last_out >= 0 && expect_gap != 0)
            begin
                assert (gap == expect_gap)
                    else report_mismatch("instr.valid gap", 32'(gap), 32'(expect_gap));
            end
            last_out = cycle;
            exp_pc   = exp_pc + 16'd4;
            n_out++;
        end
    endtask

    // Check what the last rising edge produced, then drop the redirect strobe.
    task automatic next_cycle();
        @(negedge clk);
        cycle++;
        check_output();
        redirect = '0;
    endtask

    task automatic send_redirect(input logic [ifetch_pkg::addr_w-1:0] to_addr);
        redirect = '{valid: 1'b1, target: to_addr};
        exp_pc   = to_addr;
        last_out = -1;  // Gap across a redirect is not fixed.
    endtask

    task automatic collect_outputs(input int count, input int gap);
        int goal;
        goal       = n_out + count;
        expect_gap = gap;
        while (n_out < goal)
            next_cycle();
    endtask

    task automatic random_redirects(input int count);
        int         goal;
        logic [4:0] word;
        goal       = n_out + count;
        expect_gap = 0;
        while (n_out < goal)
        begin
            next_cycle();
            if ($urandom % 16 == 0)
            begin
                word = 5'($urandom);
                send_redirect({9'b0, word, 2'b00});
            end
        end
    endtask

    a_min_gap: assert property (@(posedge clk) disable iff (rst)
        instr.valid |-> !$past(instr.valid) && !$past(instr.valid, 2))
        else abort_run($sformatf("Two instr.valid pulses closer than 3 cycles at %0t ns.",
                                 $time));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial
    begin
        void'($urandom(41));
        rst        = 1'b1;
        redirect   = '0;
        exp_pc     = '0;  // Default reset_pc.
        cycle      = 0;
        last_out   = -1;
        expect_gap = 0;
        n_out      = 0;
        $readmemh("imem.hex", ref_rom);

        repeat (16)
        begin
            @(negedge clk);
            assert (instr.valid == 1'b0)
                else abort_run("instr.valid went high while reset was asserted.");
        end
        rst      = 1'b0;
        last_out = 1;  // First request goes out one cycle after reset.

        // Cold pass, then the same 8 words from the cache.
        collect_outputs(8, miss_gap);
        send_redirect(16'd0);
        collect_outputs(8, hit_gap);

        // 64 aliases lines 0 to 7, so both passes miss.
        send_redirect(16'd64);
        collect_outputs(8, miss_gap);
        send_redirect(16'd0);
        collect_outputs(8, miss_gap);

        // Redirect during the miss for 32; that word must not appear.
        while (!dut0.mem_req.valid)
            next_cycle();
        send_redirect(16'd40);
        collect_outputs(4, 0);

        random_redirects(150);

        $display("No errors");
        $finish;
    end

endmodule

// ==== ifetch_top.sv ====
module ifetch_top #(
    parameter int                            index_w     = 4,
    parameter int                            mem_words   = 32,
    parameter int                            mem_latency = 3,
    parameter logic [ifetch_pkg::addr_w-1:0] reset_pc    = '0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  ifetch_pkg::redirect_t  redirect,
    output ifetch_pkg::fetch_rsp_t instr
);
    ifetch_pkg::fetch_req_t fetch_req;
    ifetch_pkg::fetch_rsp_t fetch_rsp;
    ifetch_pkg::mem_req_t   mem_req;
    ifetch_pkg::mem_rsp_t   mem_rsp;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // PC unit, cache, backing ROM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ifetch_pc #(
        .reset_pc (reset_pc)
    ) pc0 (
        .clk       (clk),
        .rst       (rst),
        .redirect  (redirect),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .instr     (instr)
    );

    icache #(
        .index_w (index_w)
    ) cache0 (
        .clk       (clk),
        .rst       (rst),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    imem #(
        .mem_words   (mem_words),
        .mem_latency (mem_latency)  // At least 1.
    ) mem0 (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

// ==== imem.hex ====
// One 32-bit instruction word per line, word addresses 0 to 31 in order.
00000013
00100093
00208113
00310193
00418213
00520293
00628313
00730393
0083a413
00940493
00a48513
00b50593
00c58613
00d60693
00e68713
00f70793
40208033
403100b3
40418133
405201b3
40628233
407302b3
40838333
409403b3
fe5ff06f
0000006f
12345737
89abc7b7
00112623
00c12083
00008067
0dead0b7

// ==== imem.sv ====
module imem #(
    parameter int mem_words   = 32,
    parameter int mem_latency = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  ifetch_pkg::mem_req_t mem_req,
    output ifetch_pkg::mem_rsp_t mem_rsp
);
    localparam int cnt_w = $clog2(mem_latency + 1);
    localparam int sel_w = $clog2(mem_words);

    typedef enum logic [1:0] {
        m_idle,
        m_count,
        m_done
    } mstate_t;

    mstate_t                       state;
    logic [cnt_w-1:0]              cnt;
    logic                          ready;
    logic                          fire;   // Ready goes high next cycle.
    logic [ifetch_pkg::word_w-1:0] data;
    logic [ifetch_pkg::word_w-1:0] rom [mem_words];
    logic [sel_w-1:0]              word_sel;

    initial $readmemh("imem.hex", rom);

    assign word_sel = sel_w'((mem_req.addr >> 2) % mem_words);  // Wraps.
    assign mem_rsp  = '{ready: ready, data: data};

    always_comb
    begin
        case (state)
            m_idle:  fire = mem_req.valid && (mem_latency == 1);
            m_count: fire = (cnt == cnt_w'(mem_latency - 1));
            default: fire = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= m_idle;
            cnt   <= '0;
            ready <= 1'b0;
        end
        else
        begin
            ready <= fire;
            case (state)
                m_idle:
                begin
                    if (mem_req.valid)
                    begin
                        cnt   <= cnt_w'(1);
                        state <= fire ? m_done : m_count;
                    end
                end
                m_count:
                begin
                    cnt <= cnt + cnt_w'(1);
                    if (fire)
                        state <= m_done;
                end
                m_done:
                begin
                    if (!mem_req.valid)
                        state <= m_idle;  // Request retired.
                end
                default: state <= m_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (fire)
            data <= rom[word_sel];
    end

    a_ready_with_valid: assert property (@(posedge clk) disable iff (rst)
        mem_rsp.ready |-> mem_req.valid);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch front end testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps -f ifetch.f \
    --top-module ifetch_tb -o ifetch_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/ifetch_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1
